//--- all.f
logic/heapPkg.sv
logic/commandQueue.sv
logic/arrayAllocator.sv
logic/elementStore.sv
logic/responseBuilder.sv
logic/heapUnit.sv
dv/heapScoreboard.sv
dv/heapTb.sv

//--- dv/heapScoreboard.sv
//--------------------
// Heap scoreboard
// Reference model of the array heap, checks every response
//--------------------
`timescale 1ns/1ps

module heapScoreboard #(
  parameter int arrayBits = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cmdValid,
  input  heapPkg::heapOp       cmdOp,
  input  logic [arrayBits-1:0] cmdArray,
  input  logic [indexBits-1:0] cmdIndex,
  input  logic [dataBits-1:0]  cmdData,
  input  logic                 respValid,
  input  logic [dataBits-1:0]  respData,
  input  heapPkg::heapError    respError,
  output int                   responsesSeen,
  output logic                 mismatch
);

  localparam int arrays      = 2 ** arrayBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam int maxCommands = 512;

  // Expected responses, in command order
  logic [dataBits-1:0] expData  [maxCommands];
  heapPkg::heapError   expError [maxCommands];
  logic                expKnown [maxCommands];   // Data defined
  int                  sentCount;

  // Model state
  logic                liveM  [arrays];
  int                  sizeM  [arrays];
  int                  freeStackM [$];           // Top at the back
  int                  nextUnusedM;
  logic [dataBits-1:0] wordM  [arrays][arrayLength];
  logic                knownM [arrays][arrayLength];

  logic [dataBits-1:0] frontData;
  heapPkg::heapError   frontError;
  logic                frontKnown;

  initial mismatch = 1'b0;

  assign frontData  = expData[responsesSeen];
  assign frontError = expError[responsesSeen];
  assign frontKnown = expKnown[responsesSeen];

  function automatic logic [dataBits-1:0] combine(input heapPkg::heapOp op,
      input logic [dataBits-1:0] x, input logic [dataBits-1:0] y);
    case (op)
      heapPkg::opAdd, heapPkg::opAddAfter: return x + y;  // Wraps at dataBits
      heapPkg::opSub, heapPkg::opSubAfter: return x - y;
      heapPkg::opAnd: return x & y;
      heapPkg::opOr:  return x | y;
      default:        return x ^ y;
    endcase
  endfunction

  //--------------------
  // Heap rules
  //--------------------
  task automatic predict(input heapPkg::heapOp op, input int a, input int i,
                         input logic [dataBits-1:0] d);
    heapPkg::heapError   err;
    logic [dataBits-1:0] result;
    logic [dataBits-1:0] old;
    logic [dataBits-1:0] updated;
    logic                known;
    int                  s;
    int                  grant;
    err    = heapPkg::errNone;
    result = '0;
    known  = 1'b1;
    s      = sizeM[a];
    old    = wordM[a][i];
    if (op == heapPkg::opAlloc) begin
      grant = -1;
      if (freeStackM.size() != 0) begin
        grant = freeStackM.pop_back();           // Reuse last freed
      end else if (nextUnusedM < arrays) begin
        grant       = nextUnusedM;
        nextUnusedM = nextUnusedM + 1;
      end
      if (grant < 0) begin
        err = heapPkg::errNoArrays;
      end else begin
        liveM[grant] = 1'b1;
        result       = dataBits'(grant);
      end
    end else if (!liveM[a]) begin
      err = heapPkg::errNotLive;
    end else begin
      case (op)
        heapPkg::opFree: begin
          liveM[a] = 1'b0;
          sizeM[a] = 0;
          freeStackM.push_back(a);
          result = dataBits'(a);
        end
        heapPkg::opWrite: begin
          wordM[a][i]  = d;
          knownM[a][i] = 1'b1;
          result       = d;
          if (i >= s) sizeM[a] = i + 1;
        end
        heapPkg::opRead: begin
          if (i >= s) begin
            err = heapPkg::errOutOfBounds;
          end else begin
            result = old;
            known  = knownM[a][i];
          end
        end
        heapPkg::opSize: result = dataBits'(s);
        heapPkg::opPush: begin
          if (s == arrayLength) begin
            err = heapPkg::errFull;
          end else begin
            wordM[a][s]  = d;
            knownM[a][s] = 1'b1;
            sizeM[a]     = s + 1;
            result       = d;
          end
        end
        heapPkg::opPop: begin
          if (s == 0) begin
            err = heapPkg::errEmpty;
          end else begin
            result   = wordM[a][s-1];
            known    = knownM[a][s-1];
            sizeM[a] = s - 1;
          end
        end
        default: begin
          if (i >= s) begin
            err = heapPkg::errOutOfBounds;
          end else begin
            updated     = combine(op, old, d);
            wordM[a][i] = updated;
            known       = knownM[a][i];
            if (op == heapPkg::opAddAfter || op == heapPkg::opSubAfter) result = old;
            else result = updated;
          end
        end
      endcase
    end
    if (err != heapPkg::errNone) begin
      result = '0;                              // No data on error
      known  = 1'b1;
    end
    expData[sentCount]  = result;
    expError[sentCount] = err;
    expKnown[sentCount] = known;
  endtask

  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrays; a++) begin
        liveM[a] = 1'b0;
        sizeM[a] = 0;
        for (int i = 0; i < arrayLength; i++) begin
          knownM[a][i] = 1'b0;
        end
      end
      freeStackM.delete();
      nextUnusedM = 0;
      sentCount     <= 0;
      responsesSeen <= 0;
    end else begin
      if (cmdValid) begin
        predict(cmdOp, int'(cmdArray), int'(cmdIndex), cmdData);
        sentCount <= sentCount + 1;
      end
      if (respValid) responsesSeen <= responsesSeen + 1;
    end
  end

  //--------------------
  // Response checks
  //--------------------
  respExpected: assert property (@(posedge clock) disable iff (!resetN)
    respValid |-> (responsesSeen < sentCount))
    else begin
      $display("ERROR %0t response arrived with no command outstanding", $time);
      mismatch = 1'b1;
    end

  errorMatches: assert property (@(posedge clock) disable iff (!resetN)
    respValid |-> (respError == frontError))
    else begin
      $display("ERROR %0t respError expected %0d got %0d", $time,
               $sampled(frontError), $sampled(respError));
      mismatch = 1'b1;
    end

  dataMatches: assert property (@(posedge clock) disable iff (!resetN)
    respValid |-> (!frontKnown || (respData == frontData)))
    else begin
      $display("ERROR %0t respData expected %h got %h", $time,
               $sampled(frontData), $sampled(respData));
      mismatch = 1'b1;
    end

endmodule

//--- dv/heapTb.sv
//--------------------
// Array heap testbench
// Credit-limited command stream through every heap operation
//--------------------
`timescale 1ns/1ps

module heapTb;

  localparam int arrayBits       = 3;
  localparam int indexBits       = 3;
  localparam int dataBits        = 16;
  localparam int queueDepth      = 4;
  localparam int arrayLength     = 2 ** indexBits;
  localparam int plannedCommands = 110;               // Sum over all sections
  localparam int timeoutCycles   = 40 * plannedCommands + 200;

  logic                 clock;
  logic                 resetN;
  logic                 cmdValid;
  heapPkg::heapOp       cmdOp;
  logic [arrayBits-1:0] cmdArray;
  logic [indexBits-1:0] cmdIndex;
  logic [dataBits-1:0]  cmdData;
  logic                 creditReturn;
  logic                 respValid;
  logic [dataBits-1:0]  respData;
  heapPkg::heapError    respError;

  int          responsesSeen;
  logic        mismatch;
  int          credits;
  int          commandsSent;
  int          cycleCount;
  bit          spaced;                                 // Random gaps on
  logic [31:0] rngState;

  heapPkg::heapOp rmwOps [7] = '{heapPkg::opAdd, heapPkg::opAddAfter, heapPkg::opSub,
                                 heapPkg::opSubAfter, heapPkg::opAnd, heapPkg::opOr,
                                 heapPkg::opXor};

  heapUnit #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits),
    .queueDepth(queueDepth)
  ) u_heapUnit (
    .clock       (clock),
    .resetN      (resetN),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .cmdArray    (cmdArray),
    .cmdIndex    (cmdIndex),
    .cmdData     (cmdData),
    .creditReturn(creditReturn),
    .respValid   (respValid),
    .respData    (respData),
    .respError   (respError)
  );

  heapScoreboard #(
    .arrayBits(arrayBits),
    .indexBits(indexBits),
    .dataBits (dataBits)
  ) u_heapScoreboard (
    .clock        (clock),
    .resetN       (resetN),
    .cmdValid     (cmdValid),
    .cmdOp        (cmdOp),
    .cmdArray     (cmdArray),
    .cmdIndex     (cmdIndex),
    .cmdData      (cmdData),
    .respValid    (respValid),
    .respData     (respData),
    .respError    (respError),
    .responsesSeen(responsesSeen),
    .mismatch     (mismatch)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int nextRandom(input int range);
    rngState = xorshift(rngState);
    return int'(rngState % 32'(range));
  endfunction

  // One clock edge, collecting any returned credit
  task automatic tick();
    @(posedge clock);
    cmdValid <= 1'b0;
    if (creditReturn) credits++;
  endtask

  task automatic sendCommand(input heapPkg::heapOp op, input int array, input int index,
                             input logic [dataBits-1:0] data);
    int gap;
    gap = spaced ? nextRandom(3) : 0;
    repeat (gap) tick();
    tick();
    while (credits == 0) tick();                       // Hold until a credit is back
    cmdValid <= 1'b1;
    cmdOp    <= op;
    cmdArray <= arrayBits'(array);
    cmdIndex <= indexBits'(index);
    cmdData  <= data;
    credits--;
    commandsSent++;
  endtask

  //--------------------
  // Stimulus
  //--------------------
  initial begin
    int                  idx;
    logic [dataBits-1:0] value;
    resetN       = 1'b0;
    cmdValid     = 1'b0;
    cmdOp        = heapPkg::opAlloc;
    cmdArray     = '0;
    cmdIndex     = '0;
    cmdData      = '0;
    credits      = queueDepth;
    commandsSent = 0;
    spaced       = 1'b1;
    rngState     = 32'd90;
    repeat (8) @(posedge clock);
    resetN <= 1'b1;

    repeat (9) sendCommand(heapPkg::opAlloc, 0, 0, '0);  // Ninth finds none left
    sendCommand(heapPkg::opFree, 5, 0, '0);
    sendCommand(heapPkg::opAlloc, 0, 0, '0);
    sendCommand(heapPkg::opFree, 6, 0, '0);
    sendCommand(heapPkg::opFree, 1, 0, '0);
    sendCommand(heapPkg::opAlloc, 0, 0, '0);             // Last freed first
    sendCommand(heapPkg::opAlloc, 0, 0, '0);

    sendCommand(heapPkg::opFree, 2, 0, '0);
    sendCommand(heapPkg::opFree, 2, 0, '0);              // Double free
    sendCommand(heapPkg::opRead, 2, 0, '0);
    sendCommand(heapPkg::opWrite, 2, 1, 16'h1234);
    sendCommand(heapPkg::opPop, 2, 0, '0);
    sendCommand(heapPkg::opAlloc, 0, 0, '0);

    for (int n = 0; n < 12; n++) begin
      idx   = nextRandom(arrayLength);
      value = dataBits'(nextRandom(65536));
      sendCommand(heapPkg::opWrite, 0, idx, value);
    end
    repeat (10) sendCommand(heapPkg::opRead, 0, nextRandom(arrayLength), '0);
    sendCommand(heapPkg::opSize, 0, 0, '0);
    sendCommand(heapPkg::opWrite, 1, 2, 16'hbeef);
    sendCommand(heapPkg::opSize, 1, 0, '0);
    sendCommand(heapPkg::opRead, 1, 5, '0);              // Past the size
    sendCommand(heapPkg::opRead, 1, 2, '0);

    repeat (9) sendCommand(heapPkg::opPush, 3, 0, dataBits'(nextRandom(65536)));
    repeat (9) sendCommand(heapPkg::opPop, 3, 0, '0);    // Last one on empty

    for (int n = 0; n < 4; n++) begin
      sendCommand(heapPkg::opWrite, 4, n, dataBits'(nextRandom(65536)));
    end
    for (int n = 0; n < 24; n++) begin
      idx   = nextRandom(5);                             // Index 4 is out of bounds
      value = dataBits'(nextRandom(65536));
      sendCommand(rmwOps[nextRandom(7)], 4, idx, value);
    end

    // Back-to-back burst paced only by credits
    spaced = 1'b0;
    for (int n = 0; n < 16; n++) begin
      if (n % 2 == 0) sendCommand(heapPkg::opRead, 0, nextRandom(arrayLength), '0);
      else sendCommand(heapPkg::opAdd, 4, 0, dataBits'(nextRandom(65536)));
    end

    while (responsesSeen != commandsSent || credits != queueDepth) tick();
    if (mismatch) begin
      $display("Test FAILED");
      $fatal(1, "Response check failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  initial begin
    @(posedge mismatch);
    $display("Test FAILED");
    $fatal(1, "Response check failed");
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles with %0d of %0d responses back",
             cycleCount, responsesSeen, commandsSent);
    $display("Test FAILED");
    $fatal(1, "Run did not finish in time");
  end

endmodule

//--- logic/arrayAllocator.sv
//--------------------
// Array allocator
// Live bits, LIFO of freed numbers and a never-used counter
//--------------------
`timescale 1ns/1ps

module arrayAllocator #(
  parameter int arrayBits = 3
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 headValid,
  input  heapPkg::heapOp       headOp,
  input  logic [arrayBits-1:0] headArray,
  output logic                 arrayLive,
  output logic                 allocValid,
  output logic [arrayBits-1:0] allocArray,
  output heapPkg::heapError    allocError
);

  localparam int arrays = 2 ** arrayBits;

  logic [arrays-1:0]    live;
  logic [arrayBits-1:0] freeStack [arrays];
  logic [arrayBits:0]   stackTop;        // Entries on the free stack
  logic [arrayBits:0]   nextUnused;      // First number never handed out

  logic                 isAlloc;
  logic                 isFree;
  logic                 fromStack;
  logic                 fromUnused;
  logic                 freeOk;
  logic [arrayBits-1:0] topIndex;
  logic [arrayBits-1:0] grantArray;
  heapPkg::heapError    nextError;

  assign arrayLive  = live[headArray];
  assign isAlloc    = headValid && (headOp == heapPkg::opAlloc);
  assign isFree     = headValid && (headOp == heapPkg::opFree);
  assign fromStack  = (stackTop != '0);
  assign fromUnused = !fromStack && (nextUnused < (arrayBits + 1)'(arrays));
  assign freeOk     = isFree && arrayLive;
  assign topIndex   = stackTop[arrayBits-1:0] - 1'b1;
  assign grantArray = fromStack ? freeStack[topIndex] : nextUnused[arrayBits-1:0];

  always_comb begin
    nextError = heapPkg::errNone;
    if (isAlloc && !fromStack && !fromUnused) begin
      nextError = heapPkg::errNoArrays;
    end else if (isFree && !arrayLive) begin
      nextError = heapPkg::errNotLive;  // Covers double free
    end
  end

  //--------------------
  // Allocation state
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      live       <= '0;
      stackTop   <= '0;
      nextUnused <= '0;
      allocValid <= 1'b0;
    end else begin
      allocValid <= headValid;
      if (isAlloc && fromStack) begin
        live[grantArray] <= 1'b1;
        stackTop         <= stackTop - 1'b1;
      end else if (isAlloc && fromUnused) begin
        live[grantArray] <= 1'b1;
        nextUnused       <= nextUnused + 1'b1;
      end
      if (freeOk) begin
        live[headArray] <= 1'b0;
        stackTop        <= stackTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (freeOk) freeStack[stackTop[arrayBits-1:0]] <= headArray;
    if (headValid) begin
      allocArray <= isAlloc ? grantArray : headArray;
      allocError <= nextError;
    end
  end

  // Only numbers once handed out can sit on the stack
  stackBounded: assert property (@(posedge clock) disable iff (!resetN)
    stackTop <= nextUnused);

endmodule

//--- logic/commandQueue.sv
//--------------------
// Command queue
// Circular buffer of host commands feeding a registered head,
// with one credit handed back per retired command
//--------------------
`timescale 1ns/1ps

module commandQueue #(
  parameter int arrayBits  = 3,
  parameter int indexBits  = 3,
  parameter int dataBits   = 16,
  parameter int queueDepth = 4
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cmdValid,
  input  heapPkg::heapOp       cmdOp,
  input  logic [arrayBits-1:0] cmdArray,
  input  logic [indexBits-1:0] cmdIndex,
  input  logic [dataBits-1:0]  cmdData,
  output logic                 headValid,
  output heapPkg::heapOp       headOp,
  output logic [arrayBits-1:0] headArray,
  output logic [indexBits-1:0] headIndex,
  output logic [dataBits-1:0]  headData,
  output logic                 creditReturn
);

  localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;

  heapPkg::heapOp       opMem    [queueDepth];
  logic [arrayBits-1:0] arrayMem [queueDepth];
  logic [indexBits-1:0] indexMem [queueDepth];
  logic [dataBits-1:0]  dataMem  [queueDepth];

  logic [ptrBits-1:0]   wrPtr;
  logic [ptrBits-1:0]   rdPtr;
  heapPkg::creditCount  count;
  logic                 bufferRead;

  function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
    if (ptr == ptrBits'(queueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign bufferRead = (count != '0);   // Head reloads every cycle

  //--------------------
  // Storage and head payload
  //--------------------
  always_ff @(posedge clock) begin
    if (cmdValid) begin
      opMem[wrPtr]    <= cmdOp;
      arrayMem[wrPtr] <= cmdArray;
      indexMem[wrPtr] <= cmdIndex;
      dataMem[wrPtr]  <= cmdData;
    end
    if (bufferRead) begin
      headOp    <= opMem[rdPtr];
      headArray <= arrayMem[rdPtr];
      headIndex <= indexMem[rdPtr];
      headData  <= dataMem[rdPtr];
    end
  end

  //--------------------
  // Pointers and credits
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      headValid    <= 1'b0;
      creditReturn <= 1'b0;
    end else begin
      headValid    <= bufferRead;
      creditReturn <= headValid;       // Head consumed this cycle
      if (cmdValid) wrPtr <= nextPtr(wrPtr);
      if (bufferRead) rdPtr <= nextPtr(rdPtr);
      count <= count + heapPkg::creditCount'(cmdValid)
                     - heapPkg::creditCount'(bufferRead);
    end
  end

  // A credited host always finds a free slot
  noWriteWhenFull: assert property (@(posedge clock) disable iff (!resetN)
    cmdValid |-> (count < heapPkg::creditCount'(queueDepth)));

  depthInRange: assert property (@(posedge clock)
    queueDepth <= heapPkg::maxQueueDepth);

endmodule

//--- logic/elementStore.sv
//--------------------
// Element store
// Array words and sizes, element reads, writes and
// read-modify-write ops on the queue head
//--------------------
`timescale 1ns/1ps

module elementStore #(
  parameter int arrayBits = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 headValid,
  input  heapPkg::heapOp       headOp,
  input  logic [arrayBits-1:0] headArray,
  input  logic [indexBits-1:0] headIndex,
  input  logic [dataBits-1:0]  headData,
  input  logic                 arrayLive,
  output logic                 storeValid,
  output logic [dataBits-1:0]  storeData,
  output heapPkg::heapError    storeError
);

  localparam int arrayLength = 2 ** indexBits;
  localparam int arrays      = 2 ** arrayBits;
  localparam int addrBits    = arrayBits + indexBits;

  logic [dataBits-1:0]  words [arrays * arrayLength];
  logic [indexBits:0]   sizes [arrays];

  logic [indexBits:0]   curSize;
  logic [indexBits-1:0] rdIndex;
  logic [indexBits-1:0] wrIndex;
  logic [addrBits-1:0]  rdAddr;
  logic [addrBits-1:0]  wrAddr;
  logic [dataBits-1:0]  oldWord;
  logic [dataBits-1:0]  newWord;
  logic [dataBits-1:0]  resultData;
  logic [indexBits:0]   nextSize;
  logic                 inBounds;
  logic                 isRmw;
  logic                 wordWrite;
  logic                 sizeWrite;
  logic                 commit;
  heapPkg::heapError    opError;

  assign curSize  = sizes[headArray];
  assign inBounds = ({1'b0, headIndex} < curSize);
  // Pop reads the last word, push writes just past it
  assign rdIndex  = (headOp == heapPkg::opPop) ? curSize[indexBits-1:0] - 1'b1 : headIndex;
  assign wrIndex  = (headOp == heapPkg::opPush) ? curSize[indexBits-1:0] : headIndex;
  assign rdAddr   = {headArray, rdIndex};
  assign wrAddr   = {headArray, wrIndex};
  assign oldWord  = words[rdAddr];

  //--------------------
  // Operation decode
  //--------------------
  always_comb begin
    newWord    = oldWord;
    resultData = oldWord;
    nextSize   = curSize;
    opError    = heapPkg::errNone;
    isRmw      = 1'b0;
    wordWrite  = 1'b0;
    sizeWrite  = 1'b0;
    case (headOp)
      heapPkg::opWrite: begin
        newWord    = headData;
        resultData = headData;
        wordWrite  = 1'b1;
        if (!inBounds) begin
          sizeWrite = 1'b1;               // Grow to index plus one
          nextSize  = {1'b0, headIndex} + 1'b1;
        end
      end
      heapPkg::opRead: begin
        if (!inBounds) opError = heapPkg::errOutOfBounds;
      end
      heapPkg::opSize: resultData = dataBits'(curSize);
      heapPkg::opPush: begin
        if (curSize == (indexBits + 1)'(arrayLength)) begin
          opError = heapPkg::errFull;
        end else begin
          newWord    = headData;
          resultData = headData;
          wordWrite  = 1'b1;
          sizeWrite  = 1'b1;
          nextSize   = curSize + 1'b1;
        end
      end
      heapPkg::opPop: begin
        if (curSize == '0) begin
          opError = heapPkg::errEmpty;
        end else begin
          sizeWrite = 1'b1;
          nextSize  = curSize - 1'b1;
        end
      end
      heapPkg::opAdd: begin
        isRmw      = 1'b1;
        newWord    = oldWord + headData;
        resultData = oldWord + headData;
      end
      heapPkg::opAddAfter: begin
        isRmw   = 1'b1;
        newWord = oldWord + headData;     // Old value goes back
      end
      heapPkg::opSub: begin
        isRmw      = 1'b1;
        newWord    = oldWord - headData;
        resultData = oldWord - headData;
      end
      heapPkg::opSubAfter: begin
        isRmw   = 1'b1;
        newWord = oldWord - headData;
      end
      heapPkg::opAnd: begin
        isRmw      = 1'b1;
        newWord    = oldWord & headData;
        resultData = oldWord & headData;
      end
      heapPkg::opOr: begin
        isRmw      = 1'b1;
        newWord    = oldWord | headData;
        resultData = oldWord | headData;
      end
      heapPkg::opXor: begin
        isRmw      = 1'b1;
        newWord    = oldWord ^ headData;
        resultData = oldWord ^ headData;
      end
      heapPkg::opFree: begin
        sizeWrite = 1'b1;                 // Empty for the next owner
        nextSize  = '0;
      end
      default: ;
    endcase
    if (isRmw) begin
      if (!inBounds) opError = heapPkg::errOutOfBounds;
      else wordWrite = 1'b1;
    end
    if (!arrayLive && headOp != heapPkg::opAlloc) begin
      opError = heapPkg::errNotLive;
    end
  end

  assign commit = headValid && arrayLive && (opError == heapPkg::errNone);

  //--------------------
  // State update
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrays; a++) begin
        sizes[a] <= '0;
      end
      storeValid <= 1'b0;
    end else begin
      storeValid <= headValid;
      if (commit && sizeWrite) sizes[headArray] <= nextSize;
    end
  end

  always_ff @(posedge clock) begin
    if (commit && wordWrite) words[wrAddr] <= newWord;
    if (headValid) begin
      storeData  <= resultData;
      storeError <= opError;
    end
  end

  sizeInRange: assert property (@(posedge clock) disable iff (!resetN)
    headValid |-> (curSize <= (indexBits + 1)'(arrayLength)));

endmodule

//--- logic/heapPkg.sv
//--------------------
// Array heap shared types
// Command opcodes, response status and the credit width
//--------------------
package heapPkg;

  //--------------------
  // Command opcodes
  //--------------------
  typedef enum logic [4:0] {
    opAlloc    = 5'd0,               // Hand out a fresh array
    opFree     = 5'd1,               // Return an array for reuse
    opWrite    = 5'd2,               // Store a word, grow size
    opRead     = 5'd3,               // Fetch a word
    opSize     = 5'd4,               // Current array size
    opPush     = 5'd5,               // Append at the end
    opPop      = 5'd6,               // Remove from the end
    opAdd      = 5'd7,               // Add, new value back
    opAddAfter = 5'd8,               // Add, old value back
    opSub      = 5'd9,               // Subtract, new value back
    opSubAfter = 5'd10,              // Subtract, old value back
    opAnd      = 5'd11,
    opOr       = 5'd12,
    opXor      = 5'd13
  } heapOp;

  //--------------------
  // Response status
  //--------------------
  typedef enum logic [2:0] {
    errNone        = 3'd0,
    errNotLive     = 3'd1,           // Array not allocated
    errOutOfBounds = 3'd2,           // Index at or past size
    errFull        = 3'd3,           // Push on a full array
    errEmpty       = 3'd4,           // Pop on an empty array
    errNoArrays    = 3'd5            // Every array in use
  } heapError;

  // Host credits, also the queue fill level
  typedef logic [3:0] creditCount;

  localparam int maxQueueDepth = 8;  // Fits in creditCount

endpackage

//--- logic/heapUnit.sv
//--------------------
// Array heap top level
// Command queue, allocator and element store side by side,
// response builder merging their results
//--------------------
`timescale 1ns/1ps

module heapUnit #(
  parameter int arrayBits  = 3,
  parameter int indexBits  = 3,
  parameter int dataBits   = 16,
  parameter int queueDepth = 4
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cmdValid,
  input  heapPkg::heapOp       cmdOp,
  input  logic [arrayBits-1:0] cmdArray,
  input  logic [indexBits-1:0] cmdIndex,
  input  logic [dataBits-1:0]  cmdData,
  output logic                 creditReturn,
  output logic                 respValid,
  output logic [dataBits-1:0]  respData,
  output heapPkg::heapError    respError
);

  //--------------------
  // Queue head
  //--------------------
  logic                 headValid;
  heapPkg::heapOp       headOp;
  logic [arrayBits-1:0] headArray;
  logic [indexBits-1:0] headIndex;
  logic [dataBits-1:0]  headData;

  //--------------------
  // Execution results
  //--------------------
  logic                 arrayLive;
  logic                 allocValid;
  logic [arrayBits-1:0] allocArray;
  heapPkg::heapError    allocError;
  logic                 storeValid;
  logic [dataBits-1:0]  storeData;
  heapPkg::heapError    storeError;

  commandQueue #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits),
    .queueDepth(queueDepth)
  ) u_commandQueue (
    .clock       (clock),
    .resetN      (resetN),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .cmdArray    (cmdArray),
    .cmdIndex    (cmdIndex),
    .cmdData     (cmdData),
    .headValid   (headValid),
    .headOp      (headOp),
    .headArray   (headArray),
    .headIndex   (headIndex),
    .headData    (headData),
    .creditReturn(creditReturn)
  );

  arrayAllocator #(
    .arrayBits(arrayBits)
  ) u_arrayAllocator (
    .clock     (clock),
    .resetN    (resetN),
    .headValid (headValid),
    .headOp    (headOp),
    .headArray (headArray),
    .arrayLive (arrayLive),
    .allocValid(allocValid),
    .allocArray(allocArray),
    .allocError(allocError)
  );

  elementStore #(
    .arrayBits(arrayBits),
    .indexBits(indexBits),
    .dataBits (dataBits)
  ) u_elementStore (
    .clock     (clock),
    .resetN    (resetN),
    .headValid (headValid),
    .headOp    (headOp),
    .headArray (headArray),
    .headIndex (headIndex),
    .headData  (headData),
    .arrayLive (arrayLive),
    .storeValid(storeValid),
    .storeData (storeData),
    .storeError(storeError)
  );

  responseBuilder #(
    .arrayBits(arrayBits),
    .dataBits (dataBits)
  ) u_responseBuilder (
    .clock     (clock),
    .resetN    (resetN),
    .headValid (headValid),
    .headOp    (headOp),
    .allocValid(allocValid),
    .allocArray(allocArray),
    .allocError(allocError),
    .storeValid(storeValid),
    .storeData (storeData),
    .storeError(storeError),
    .respValid (respValid),
    .respData  (respData),
    .respError (respError)
  );

endmodule

//--- logic/responseBuilder.sv
//--------------------
// Response builder
// Picks allocator or store result by opcode and registers it
//--------------------
`timescale 1ns/1ps

module responseBuilder #(
  parameter int arrayBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 headValid,
  input  heapPkg::heapOp       headOp,
  input  logic                 allocValid,
  input  logic [arrayBits-1:0] allocArray,
  input  heapPkg::heapError    allocError,
  input  logic                 storeValid,
  input  logic [dataBits-1:0]  storeData,
  input  heapPkg::heapError    storeError,
  output logic                 respValid,
  output logic [dataBits-1:0]  respData,
  output heapPkg::heapError    respError
);

  heapPkg::heapOp      headOpDelayed;   // Opcode of the results now arriving
  logic                useAlloc;
  logic [dataBits-1:0] pickedData;
  heapPkg::heapError   pickedError;

  always_ff @(posedge clock) begin
    if (headValid) headOpDelayed <= headOp;
  end

  assign useAlloc    = (headOpDelayed == heapPkg::opAlloc) ||
                       (headOpDelayed == heapPkg::opFree);
  assign pickedData  = useAlloc ? dataBits'(allocArray) : storeData;
  assign pickedError = useAlloc ? allocError : storeError;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
    end else begin
      respValid <= allocValid && storeValid;
    end
  end

  always_ff @(posedge clock) begin
    if (allocValid) begin
      respError <= pickedError;
      respData  <= (pickedError == heapPkg::errNone) ? pickedData : '0;
    end
  end

  // Both halves consume the same head, so they finish together
  resultsAligned: assert property (@(posedge clock) disable iff (!resetN)
    allocValid == storeValid);

endmodule
